// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mcbsp_frame_tx
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/mcbsp_frame_tx_assertions.sv
`timescale 1ns/1ps
`include "mcbsp_defines.svh"

module mcbsp_frame_tx_assertions import mcbsp_pkg::*; (
	input logic       i_clk,
	input logic       i_reset_n,
	input logic       i_tx_start,
	input logic       i_mc_clk,
	input logic       i_mc_fs,
	input logic       i_mc_dx,
	input frame_cmd_t i_cmd,
	input logic       i_cmd_valid,
	input logic       i_cmd_ready,
	input tx_word_t   i_word,
	input logic       i_word_valid,
	input logic       i_word_ready
);

	localparam int BIT_CYC = 2 * `MC_BIT_DIV;   // i_clk cycles per bit

	int unsigned fail_cnt = 0;
	logic [3:0]  fs_len;                         // cycles the frame sync has been high
	logic        req_seen;

	always_ff @(posedge i_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			fs_len   <= '0;
			req_seen <= 1'b0;
		end else begin
			fs_len <= i_mc_fs ? fs_len + 1'b1 : '0;
			if (i_tx_start)
				req_seen <= 1'b1;
		end
	end

	// ---------------------------------------------------------------------------
	// handshakes hold until taken
	// ---------------------------------------------------------------------------
	a_cmd_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		i_cmd_valid && !i_cmd_ready |=> i_cmd_valid && $stable(i_cmd))
		else begin
			fail_cnt++;
			$error("frame order dropped or changed before the builder took it");
		end

	a_word_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		i_word_valid && !i_word_ready |=> i_word_valid && $stable(i_word))
		else begin
			fail_cnt++;
			$error("frame word dropped or changed before the serializer took it");
		end

	// serial line
	a_fs_width: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		$fell(i_mc_fs) |-> fs_len == 4'(BIT_CYC))
		else begin
			fail_cnt++;
			$error("frame sync not exactly one bit period wide");
		end

	a_dx_on_fall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		$changed(i_mc_dx) |-> $fell(i_mc_clk))
		else begin
			fail_cnt++;
			$error("data line moved away from a falling bit clock");
		end

	a_idle_line: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		!req_seen |-> !i_mc_fs && i_mc_dx)
		else begin
			fail_cnt++;
			$error("serial line not idle before the first request");
		end

endmodule

bind mcbsp_frame_tx mcbsp_frame_tx_assertions u_assertions (
	.i_clk        (i_clk),
	.i_reset_n    (i_reset_n),
	.i_tx_start   (i_tx_start),
	.i_mc_clk     (o_mc_clk),
	.i_mc_fs      (o_mc_fs),
	.i_mc_dx      (o_mc_dx),
	.i_cmd        (cmd),
	.i_cmd_valid  (cmd_valid),
	.i_cmd_ready  (cmd_ready),
	.i_word       (word),
	.i_word_valid (word_valid),
	.i_word_ready (word_ready)
);

// File: dv/tb_mcbsp_frame_tx.sv
`timescale 1ns/1ps
`include "mcbsp_defines.svh"

module tb_mcbsp_frame_tx import mcbsp_pkg::*; ();

	localparam int FRAME_WORDS = 3 + `MC_STATUS_WORDS + `MC_PHASES * `MC_UDC_MODULES + 1;
	localparam int RISE_TIMEOUT = 64;          // i_clk cycles for one bit clock rise
	localparam int FS_TIMEOUT   = 400;         // bit periods until the frame sync
	localparam int FRAME_READS  = `MC_PHASES * `MC_UDC_MODULES;
	localparam logic [`MC_WORD_W-1:0] NO_DATA = 16'hdead;   // never a module voltage

	logic                  clk;
	logic                  reset_n     = 1'b0;
	logic                  tx_start    = 1'b0;
	mc_status_t            status      = '0;
	udc_rd_t               udc_rd;
	logic [`MC_WORD_W-1:0] udc_rd_data = '0;
	logic                  mc_clk;
	logic                  mc_fs;
	logic                  mc_dx;
	int                    seed;
	int                    frame_cnt;
	int                    rd_cnt      = 0;
	logic [`MC_WORD_W-1:0] exp_words [FRAME_WORDS];
	logic [`MC_WORD_W-1:0] got_words [FRAME_WORDS];

	mcbsp_frame_tx i_dut (
		.i_clk         (clk),
		.i_reset_n     (reset_n),
		.i_tx_start    (tx_start),
		.i_status      (status),
		.o_udc_rd      (udc_rd),
		.i_udc_rd_data (udc_rd_data),
		.o_mc_clk      (mc_clk),
		.o_mc_fs       (mc_fs),
		.o_mc_dx       (mc_dx)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ---------------------------------------------------------------------------
	// module-voltage memory model, one cycle read latency
	// ---------------------------------------------------------------------------
	function automatic logic [`MC_WORD_W-1:0] udc_value(input logic [1:0] ph,
			input logic [`MC_UDC_IDX_W-1:0] idx);
		return {ph, 4'h5, idx, idx ^ 5'h1b};
	endfunction

	always @(posedge clk) begin
		if (udc_rd.en) begin
			udc_rd_data <= udc_value(udc_rd.phase, udc_rd.idx);
			rd_cnt++;
		end else begin
			udc_rd_data <= NO_DATA;             // data only valid right after a read
		end
	end

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	always @(posedge clk) begin
		if (i_dut.u_assertions.fail_cnt != 0)
			fail_now("a protocol assertion on the DUT failed");
	end

	task automatic draw_status(output mc_status_t st);
		logic [31:0] r;
		for (int i = 0; i < `MC_STATUS_WORDS; i++) begin
			r = $random(seed);
			st[i*`MC_WORD_W +: `MC_WORD_W] = r[`MC_WORD_W-1:0];
		end
	endtask

	// status words in frame order
	function automatic logic [`MC_WORD_W-1:0] status_word(input mc_status_t st, input int i);
		case (i)
			0:       return st.control_word;
			1:       return st.target_vol_a;
			2:       return st.target_vol_b;
			3:       return st.target_vol_c;
			4:       return st.phase_sta;
			5:       return st.record_grp;
			6:       return st.udc_bus_a;
			7:       return st.udc_bus_b;
			default: return st.udc_bus_c;
		endcase
	endfunction

	task automatic build_expected(input logic [`MC_WORD_W-1:0] cnt, input mc_status_t st);
		int                    n;
		logic [`MC_WORD_W-1:0] sum;
		exp_words[0] = `MC_HDR_WORD0;
		exp_words[1] = `MC_HDR_WORD1;
		exp_words[2] = cnt;
		n = 3;
		for (int i = 0; i < `MC_STATUS_WORDS; i++) begin
			exp_words[n] = status_word(st, i);
			n++;
		end
		for (int p = 0; p < `MC_PHASES; p++) begin
			for (int m = 0; m < `MC_UDC_MODULES; m++) begin
				exp_words[n] = udc_value(2'(p), `MC_UDC_IDX_W'(m));
				n++;
			end
		end
		sum = '0;
		for (int i = 2; i < n; i++)
			sum = sum + exp_words[i];     // count through last module voltage
		exp_words[n] = ~sum;
	endtask

	// ---------------------------------------------------------------------------
	// receiver, samples on the rising bit clock
	// ---------------------------------------------------------------------------
	task automatic next_rise(output logic fs_s, output logic dx_s);
		int   n;
		logic prev;
		n    = 0;
		prev = mc_clk;
		@(posedge clk);
		while (!(prev == 1'b0 && mc_clk == 1'b1)) begin
			n++;
			if (n > RISE_TIMEOUT)
				fail_now("timeout: the bit clock stopped rising");
			prev = mc_clk;
			@(posedge clk);
		end
		fs_s = mc_fs;
		dx_s = mc_dx;
	endtask

	task automatic receive_frame();
		logic                  fs_s;
		logic                  dx_s;
		int                    n;
		logic [`MC_WORD_W-1:0] w;
		n    = 0;
		fs_s = 1'b0;
		while (!fs_s) begin
			n++;
			if (n > FS_TIMEOUT)
				fail_now("timeout: no frame sync after the request");
			next_rise(fs_s, dx_s);
		end
		for (int i = 0; i < FRAME_WORDS; i++) begin
			w = '0;
			for (int b = 0; b < `MC_WORD_W; b++) begin
				next_rise(fs_s, dx_s);
				w = {w[`MC_WORD_W-2:0], dx_s};   // msb arrives first
			end
			got_words[i] = w;
		end
	endtask

	task automatic check_frame(input string name);
		for (int i = 0; i < FRAME_WORDS; i++) begin
			assert (got_words[i] == exp_words[i])
				else fail_now($sformatf("MISMATCH %s word %0d expected %h actual %h",
					name, i, exp_words[i], got_words[i]));
		end
		// one memory read per module voltage, none while a word waits
		assert (rd_cnt == frame_cnt * FRAME_READS)
			else fail_now($sformatf("MISMATCH %s reads expected %0d actual %0d",
				name, frame_cnt * FRAME_READS, rd_cnt));
	endtask

	task automatic run_frame(input string name, input mc_status_t st,
			input mc_status_t st_after, input bit extra_edge);
		frame_cnt++;
		build_expected(`MC_WORD_W'(frame_cnt), st);
		fork
			begin
				@(posedge clk);
				status   <= st;
				tx_start <= 1'b1;
				repeat (6) @(posedge clk);
				tx_start <= 1'b0;
				status   <= st_after;           // snapshot is already latched
				if (extra_edge) begin
					repeat (300) @(posedge clk);
					tx_start <= 1'b1;           // lands inside the running frame
					repeat (6) @(posedge clk);
					tx_start <= 1'b0;
				end
			end
			receive_frame();
		join
		check_frame(name);
		repeat (20) @(posedge clk);
	endtask

	initial begin
		mc_status_t s_a;
		mc_status_t s_b;
		mc_status_t s_c;
		seed      = 32'h713c_8681;
		frame_cnt = 0;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		repeat (200) @(posedge clk);            // quiet line, no request yet
		draw_status(s_a);
		draw_status(s_b);
		draw_status(s_c);
		run_frame("snapshot_hold", s_a, s_b, 1'b0);
		run_frame("second_request", s_b, s_b, 1'b0);
		run_frame("busy_ignore", s_c, s_c, 1'b1);
		run_frame("count_after_busy", s_a, s_a, 1'b0);
		if (i_dut.u_assertions.fail_cnt != 0) begin
			fail_now("a protocol assertion on the DUT failed");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// File: hdl/mcbsp_defines.svh
`ifndef MCBSP_DEFINES_SVH
`define MCBSP_DEFINES_SVH

// ---------------------------------------------------------------------------
// frame layout
// ---------------------------------------------------------------------------
`define MC_WORD_W        16
`define MC_UDC_MODULES   18         // series modules per phase
`define MC_PHASES        3
`define MC_STATUS_WORDS  9
`define MC_HDR_WORD0     16'h8000
`define MC_HDR_WORD1     16'h7fff

// ---------------------------------------------------------------------------
// bit clock and counter widths
// ---------------------------------------------------------------------------
`define MC_BIT_DIV       2          // i_clk cycles per half bit clock
`define MC_DIV_CNT_W     2
`define MC_BIT_CNT_W     4          // bit position inside a word
`define MC_STAT_IDX_W    4
`define MC_UDC_IDX_W     5

`endif

// File: hdl/mcbsp_frame_builder.sv
`timescale 1ns/1ps
`include "mcbsp_defines.svh"

module mcbsp_frame_builder import mcbsp_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_reset_n,
	input  frame_cmd_t            i_cmd,
	input  logic                  i_cmd_valid,
	output logic                  o_cmd_ready,
	output udc_rd_t               o_udc_rd,
	input  logic [`MC_WORD_W-1:0] i_udc_rd_data,
	output tx_word_t              o_word,
	output logic                  o_word_valid,
	input  logic                  i_word_ready
);

	typedef enum logic [2:0] {
		ST_IDLE, ST_HDR0, ST_HDR1, ST_COUNT, ST_STATUS, ST_UDC_RD, ST_UDC_WAIT, ST_SUM
	} state_t;

	localparam logic [`MC_STAT_IDX_W-1:0] STAT_LAST  = `MC_STAT_IDX_W'(`MC_STATUS_WORDS - 1);
	localparam logic [`MC_UDC_IDX_W-1:0]  UDC_LAST   = `MC_UDC_IDX_W'(`MC_UDC_MODULES - 1);
	localparam logic [1:0]                PHASE_LAST = 2'(`MC_PHASES - 1);

	state_t                               state;
	frame_cmd_t                           cmd_q;
	logic [`MC_STATUS_WORDS*`MC_WORD_W-1:0] stat_flat;
	logic [`MC_STAT_IDX_W-1:0]            stat_idx;
	logic [1:0]                           phase;
	logic [`MC_UDC_IDX_W-1:0]             udc_idx;
	logic [`MC_WORD_W-1:0]                sum;
	logic                                 slot_free;
	logic                                 rd_fire;
	logic                                 emit;
	logic                                 emit_last;
	logic                                 sum_clr;
	logic                                 sum_add;
	logic [`MC_WORD_W-1:0]                emit_data;

	assign slot_free   = ~o_word_valid | i_word_ready;   // output register free next cycle
	assign o_cmd_ready = (state == ST_IDLE);
	assign stat_flat   = cmd_q.status;
	assign rd_fire     = (state == ST_UDC_RD) && slot_free;
	assign o_udc_rd    = '{en: rd_fire, phase: phase, idx: udc_idx};

	// word selection per section
	always_comb begin
		emit      = 1'b0;
		emit_data = '0;
		emit_last = 1'b0;
		sum_clr   = 1'b0;
		sum_add   = 1'b0;
		case (state)
			ST_HDR0: begin
				emit      = slot_free;
				emit_data = `MC_HDR_WORD0;
			end
			ST_HDR1: begin
				emit      = slot_free;
				emit_data = `MC_HDR_WORD1;
			end
			ST_COUNT: begin
				emit      = slot_free;
				emit_data = cmd_q.update_cnt;
				sum_clr   = 1'b1;                   // checksum starts at the count
			end
			ST_STATUS: begin
				emit      = slot_free;
				emit_data = stat_flat[(`MC_STATUS_WORDS - 1 - stat_idx) * `MC_WORD_W +: `MC_WORD_W];
				sum_add   = 1'b1;
			end
			ST_UDC_WAIT: begin
				emit      = 1'b1;                   // slot emptied during the read cycle
				emit_data = i_udc_rd_data;
				sum_add   = 1'b1;
			end
			ST_SUM: begin
				emit      = slot_free;
				emit_data = ~sum;
				emit_last = 1'b1;
			end
			default: ;
		endcase
	end

	// ---------------------------------------------------------------------------
	// section sequencer
	// ---------------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			state        <= ST_IDLE;
			o_word_valid <= 1'b0;
			stat_idx     <= '0;
			phase        <= '0;
			udc_idx      <= '0;
		end else begin
			if (emit)
				o_word_valid <= 1'b1;
			else if (i_word_ready)
				o_word_valid <= 1'b0;
			case (state)
				ST_IDLE:   if (i_cmd_valid) state <= ST_HDR0;
				ST_HDR0:   if (slot_free) state <= ST_HDR1;
				ST_HDR1:   if (slot_free) state <= ST_COUNT;
				ST_COUNT: if (slot_free) begin
					state    <= ST_STATUS;
					stat_idx <= '0;
				end
				ST_STATUS: if (slot_free) begin
					if (stat_idx == STAT_LAST) begin
						state   <= ST_UDC_RD;
						phase   <= '0;
						udc_idx <= '0;
					end else begin
						stat_idx <= stat_idx + 1'b1;
					end
				end
				ST_UDC_RD: if (slot_free) state <= ST_UDC_WAIT;
				ST_UDC_WAIT: begin
					state <= ST_UDC_RD;
					if (udc_idx != UDC_LAST) begin
						udc_idx <= udc_idx + 1'b1;
					end else begin
						udc_idx <= '0;
						if (phase == PHASE_LAST)
							state <= ST_SUM;
						else
							phase <= phase + 1'b1;   // next phase, a then b then c
					end
				end
				ST_SUM:    if (slot_free) state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_cmd_valid && o_cmd_ready)
			cmd_q <= i_cmd;
		if (emit)
			o_word <= '{data: emit_data, last: emit_last};
		if (emit && sum_clr)
			sum <= emit_data;
		else if (emit && sum_add)
			sum <= sum + emit_data;
	end

endmodule

// File: hdl/mcbsp_frame_trigger.sv
`timescale 1ns/1ps
`include "mcbsp_defines.svh"

module mcbsp_frame_trigger import mcbsp_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset_n,
	input  logic       i_tx_start,
	input  mc_status_t i_status,
	input  logic       i_frame_done,
	output frame_cmd_t o_cmd,
	output logic       o_cmd_valid,
	input  logic       i_cmd_ready
);

	logic [2:0]            req_sync;    // two sync flops plus edge history
	logic                  busy;
	logic                  start;
	logic [`MC_WORD_W-1:0] upd_cnt;
	mc_status_t            snap;

	// rising edge of the synchronized request, dropped while a frame runs
	assign start = req_sync[1] & ~req_sync[2] & ~busy;

	always_ff @(posedge i_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			req_sync    <= '0;
			busy        <= 1'b0;
			upd_cnt     <= '0;
			o_cmd_valid <= 1'b0;
		end else begin
			req_sync <= {req_sync[1:0], i_tx_start};
			if (start) begin
				busy        <= 1'b1;
				upd_cnt     <= upd_cnt + 1'b1;   // first frame carries 1
				o_cmd_valid <= 1'b1;
			end else begin
				if (i_frame_done)
					busy <= 1'b0;
				if (o_cmd_valid && i_cmd_ready)
					o_cmd_valid <= 1'b0;
			end
		end
	end

	// ---------------------------------------------------------------------------
	// status snapshot, frozen at the accepted edge
	// ---------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (start)
			snap <= i_status;
	end

	assign o_cmd = '{update_cnt: upd_cnt, status: snap};

endmodule

// File: hdl/mcbsp_frame_tx.sv
`timescale 1ns/1ps
`include "mcbsp_defines.svh"

module mcbsp_frame_tx import mcbsp_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_reset_n,
	input  logic                  i_tx_start,
	input  mc_status_t            i_status,
	output udc_rd_t               o_udc_rd,
	input  logic [`MC_WORD_W-1:0] i_udc_rd_data,
	output logic                  o_mc_clk,
	output logic                  o_mc_fs,
	output logic                  o_mc_dx
);

	frame_cmd_t cmd;
	logic       cmd_valid;
	logic       cmd_ready;
	tx_word_t   word;
	logic       word_valid;
	logic       word_ready;
	logic       frame_done;

	// ---------------------------------------------------------------------------
	// trigger -> builder -> serializer
	// ---------------------------------------------------------------------------
	mcbsp_frame_trigger u_trigger (
		.i_clk        (i_clk),
		.i_reset_n    (i_reset_n),
		.i_tx_start   (i_tx_start),
		.i_status     (i_status),
		.i_frame_done (frame_done),
		.o_cmd        (cmd),
		.o_cmd_valid  (cmd_valid),
		.i_cmd_ready  (cmd_ready)
	);

	mcbsp_frame_builder u_builder (
		.i_clk         (i_clk),
		.i_reset_n     (i_reset_n),
		.i_cmd         (cmd),
		.i_cmd_valid   (cmd_valid),
		.o_cmd_ready   (cmd_ready),
		.o_udc_rd      (o_udc_rd),
		.i_udc_rd_data (i_udc_rd_data),
		.o_word        (word),
		.o_word_valid  (word_valid),
		.i_word_ready  (word_ready)
	);

	mcbsp_serializer u_serializer (
		.i_clk        (i_clk),
		.i_reset_n    (i_reset_n),
		.i_word       (word),
		.i_word_valid (word_valid),
		.o_word_ready (word_ready),
		.o_frame_done (frame_done),   // releases the trigger
		.o_mc_clk     (o_mc_clk),
		.o_mc_fs      (o_mc_fs),
		.o_mc_dx      (o_mc_dx)
	);

endmodule

// File: hdl/mcbsp_pkg.sv
`include "mcbsp_defines.svh"

package mcbsp_pkg;

	// status words, first field goes out first
	typedef struct packed {
		logic [`MC_WORD_W-1:0] control_word;
		logic [`MC_WORD_W-1:0] target_vol_a;
		logic [`MC_WORD_W-1:0] target_vol_b;
		logic [`MC_WORD_W-1:0] target_vol_c;
		logic [`MC_WORD_W-1:0] phase_sta;
		logic [`MC_WORD_W-1:0] record_grp;
		logic [`MC_WORD_W-1:0] udc_bus_a;    // dc bus voltage per phase
		logic [`MC_WORD_W-1:0] udc_bus_b;
		logic [`MC_WORD_W-1:0] udc_bus_c;
	} mc_status_t;

	// one frame order from trigger to builder
	typedef struct packed {
		logic [`MC_WORD_W-1:0] update_cnt;
		mc_status_t            status;
	} frame_cmd_t;

	// module-voltage memory read request
	typedef struct packed {
		logic                     en;
		logic [1:0]               phase;     // 0 = a, 1 = b, 2 = c
		logic [`MC_UDC_IDX_W-1:0] idx;
	} udc_rd_t;

	// frame word on its way to the serializer
	typedef struct packed {
		logic [`MC_WORD_W-1:0] data;
		logic                  last;      // checksum word closes the frame
	} tx_word_t;

endpackage

// File: hdl/mcbsp_serializer.sv
`timescale 1ns/1ps
`include "mcbsp_defines.svh"

module mcbsp_serializer import mcbsp_pkg::*; (
	input  logic     i_clk,
	input  logic     i_reset_n,
	input  tx_word_t i_word,
	input  logic     i_word_valid,
	output logic     o_word_ready,
	output logic     o_frame_done,
	output logic     o_mc_clk,
	output logic     o_mc_fs,
	output logic     o_mc_dx
);

	typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_SHIFT} state_t;

	localparam logic [`MC_DIV_CNT_W-1:0] DIV_LAST = `MC_DIV_CNT_W'(`MC_BIT_DIV - 1);
	localparam logic [`MC_BIT_CNT_W-1:0] BIT_LAST = `MC_BIT_CNT_W'(`MC_WORD_W - 1);

	state_t                   state;
	logic [`MC_DIV_CNT_W-1:0] div_cnt;
	logic                     tick;
	logic                     fall;
	logic                     buf_valid;
	tx_word_t                 buf_q;
	logic [`MC_WORD_W-1:0]    sh;
	logic                     sh_last;
	logic [`MC_BIT_CNT_W-1:0] bit_cnt;
	logic                     load;

	assign tick         = (div_cnt == DIV_LAST);
	assign fall         = tick & o_mc_clk;              // bit clock about to drop
	assign o_word_ready = ~buf_valid;
	assign load         = fall && buf_valid &&
	                      ((state == ST_LOAD) ||
	                       (state == ST_SHIFT && bit_cnt == BIT_LAST && !sh_last));

	// ---------------------------------------------------------------------------
	// bit clock, runs from reset on
	// ---------------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			div_cnt  <= '0;
			o_mc_clk <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
				o_mc_clk <= ~o_mc_clk;
		end
	end

	// framing and data line, all changes on the falling bit clock
	always_ff @(posedge i_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			state        <= ST_IDLE;
			buf_valid    <= 1'b0;
			bit_cnt      <= '0;
			o_mc_fs      <= 1'b0;
			o_mc_dx      <= 1'b1;
			o_frame_done <= 1'b0;
		end else begin
			o_frame_done <= 1'b0;
			if (i_word_valid && o_word_ready)
				buf_valid <= 1'b1;
			else if (load)
				buf_valid <= 1'b0;
			if (fall) begin
				case (state)
					ST_IDLE: if (buf_valid) begin
						o_mc_fs <= 1'b1;                 // one bit ahead of the data
						state   <= ST_LOAD;
					end
					ST_LOAD: begin
						o_mc_fs <= 1'b0;
						if (buf_valid) begin
							o_mc_dx <= buf_q.data[`MC_WORD_W-1];
							bit_cnt <= '0;
							state   <= ST_SHIFT;
						end
					end
					ST_SHIFT: begin
						if (bit_cnt != BIT_LAST) begin
							o_mc_dx <= sh[`MC_WORD_W-2];
							bit_cnt <= bit_cnt + 1'b1;
						end else if (sh_last) begin
							o_mc_dx      <= 1'b1;        // line back to idle
							o_frame_done <= 1'b1;
							state        <= ST_IDLE;
						end else if (buf_valid) begin
							o_mc_dx <= buf_q.data[`MC_WORD_W-1];
							bit_cnt <= '0;
						end else begin
							o_mc_dx <= 1'b1;             // underrun, wait for a word
							state   <= ST_LOAD;
						end
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_word_valid && o_word_ready)
			buf_q <= i_word;
		if (load) begin
			sh      <= buf_q.data;
			sh_last <= buf_q.last;
		end else if (fall && state == ST_SHIFT) begin
			sh <= {sh[`MC_WORD_W-2:0], 1'b0};   // msb first
		end
	end

endmodule

// File: project.f
+incdir+hdl
hdl/mcbsp_pkg.sv
hdl/mcbsp_frame_trigger.sv
hdl/mcbsp_frame_builder.sv
hdl/mcbsp_serializer.sv
hdl/mcbsp_frame_tx.sv
dv/mcbsp_frame_tx_assertions.sv
dv/tb_mcbsp_frame_tx.sv
